//--- sim/oramTests.txt
# name op addr data, addr and data in hex
# op W writes data, op R reads and expects data
rdEmpty R 5 0000
wrRd W 3 1234
wrRd R 3 1234
multi W 0 a0a0
multi W 7 b7b7
multi W c c3c3
multi R 7 b7b7
multi R 0 a0a0
multi R c c3c3
overwrite W 3 5555
overwrite R 3 5555
stallRd R 7 b7b7
stallRd R 3 5555
mixed W 1 1111
mixed W 2 2222
mixed W 4 4444
mixed W 5 5005
mixed W 6 6666
mixed W 8 8888
mixed W 9 9999
mixed W a aaaa
mixed W b bbbb
mixed W d dddd
mixed W e eeee
mixed W f ffff
mixed R f ffff
mixed R 1 1111
mixed W 0 0f0f
mixed R 0 0f0f
mixed R 5 5005
mixed R 3 5555
mixed R e eeee
mixed R 2 2222
mixed W 9 9a9a
mixed R 9 9a9a
mixed R c c3c3
mixed R 7 b7b7
mixed R d dddd
mixed R 4 4444
mixed R a aaaa
mixed R 8 8888
mixed R b bbbb
mixed R 6 6666

//--- pathOramTop.f
hdl/oramPkg.sv
hdl/positionMap.sv
hdl/treeMemory.sv
hdl/pathBuffer.sv
hdl/stashController.sv
hdl/pathOramTop.sv
sim/pathOramTop_chk.sv
sim/pathOramTb.sv

//--- run.sh
#!/bin/sh
# Build and run the Path ORAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module pathOramTb -f pathOramTop.f -o simPathOram
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simPathOram > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi
exit 0

//--- sim/pathOramTb.sv
/*
 * Path ORAM testbench
 * File-driven accesses with random idle gaps and reply stalls
 */
module pathOramTb;

	localparam int WaitLimit = 200;

	logic Clock;
	logic rst;
	oramPkg::oramCmd Cmd;
	logic [oramPkg::ORAMU-1:0] PAddr;
	logic [oramPkg::FEDWidth-1:0] DataIn;
	logic CmdValid;
	logic CmdReady;
	logic [oramPkg::FEDWidth-1:0] DataOut;
	logic DataOutValid;
	logic DataOutReady;

	// Random source for gaps and stalls
	logic [31:0] lfsrState;

	// Last written value per address, zero if never written
	logic [oramPkg::FEDWidth-1:0] shadow [oramPkg::NumBlocks];

	pathOramTop dut0 (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.PAddr(PAddr),
		.DataIn(DataIn),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	//----------------------------------------------------------------------
	// Random bits and failure handling
	//----------------------------------------------------------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	task automatic randomBits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic abortRun();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkData(
		input logic [127:0] name,
		input logic [oramPkg::FEDWidth-1:0] expected,
		input logic [oramPkg::FEDWidth-1:0] actual
	);
		if (actual !== expected) begin
			$display("Fail %0s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	// Handshake levels seen during an access
	task automatic checkFlag(
		input logic [127:0] name,
		input string what,
		input logic expected,
		input logic actual
	);
		if (actual !== expected) begin
			$display("Fail %0s %s: expected %b, actual %b", name, what, expected, actual);
			abortRun();
		end
	endtask

	//----------------------------------------------------------------------
	// Access tasks, all driving on the falling edge
	//----------------------------------------------------------------------
	task automatic issueCmd(
		input logic [127:0] name,
		input oramPkg::oramCmd op,
		input logic [oramPkg::ORAMU-1:0] addr,
		input logic [oramPkg::FEDWidth-1:0] data
	);
		int gap;
		int waitCnt;
		randomBits(2, gap);
		repeat (gap) @(negedge Clock);
		waitCnt = 0;
		while (!CmdReady) begin
			waitCnt++;
			if (waitCnt > WaitLimit) begin
				$display("Timeout: CmdReady never rose before test %0s", name);
				abortRun();
			end
			@(negedge Clock);
		end
		Cmd = op;
		PAddr = addr;
		DataIn = data;
		CmdValid = 1'b1;
		// Ready was high, so the next rising edge takes it
		@(negedge Clock);
		CmdValid = 1'b0;
	endtask

	task automatic writeBlock(
		input logic [127:0] name,
		input logic [oramPkg::ORAMU-1:0] addr,
		input logic [oramPkg::FEDWidth-1:0] data
	);
		int waitCnt;
		issueCmd(name, oramPkg::cmdWrite, addr, data);
		waitCnt = 0;
		// Write ends when the frontend frees up
		while (!CmdReady) begin
			checkFlag(name, "DataOutValid", 1'b0, DataOutValid);
			waitCnt++;
			if (waitCnt > WaitLimit) begin
				$display("Timeout: write in test %0s never completed", name);
				abortRun();
			end
			@(negedge Clock);
		end
	endtask

	task automatic readBlock(
		input logic [127:0] name,
		input logic [oramPkg::ORAMU-1:0] addr,
		input logic [oramPkg::FEDWidth-1:0] expected
	);
		int waitCnt;
		int stall;
		issueCmd(name, oramPkg::cmdRead, addr, '0);
		waitCnt = 0;
		while (!DataOutValid) begin
			// No second command while this one is open
			checkFlag(name, "CmdReady", 1'b0, CmdReady);
			waitCnt++;
			if (waitCnt > WaitLimit) begin
				$display("Timeout: read in test %0s returned no data", name);
				abortRun();
			end
			@(negedge Clock);
		end
		checkData(name, expected, DataOut);
		// Hold the reply off for a few cycles
		randomBits(3, stall);
		repeat (stall) begin
			@(negedge Clock);
			checkFlag(name, "DataOutValid", 1'b1, DataOutValid);
			checkFlag(name, "CmdReady", 1'b0, CmdReady);
			checkData(name, expected, DataOut);
		end
		DataOutReady = 1'b1;
		@(negedge Clock);
		DataOutReady = 1'b0;
		checkFlag(name, "DataOutValid", 1'b0, DataOutValid);
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial begin
		int fd;
		int code;
		int testCount;
		logic [127:0] tok;
		logic [7:0] opTok;
		logic [oramPkg::ORAMU-1:0] addr;
		logic [oramPkg::FEDWidth-1:0] value;
		logic [8*120-1:0] lineBuf;

		lfsrState = 32'h0993_9f02;
		rst = 1'b1;
		Cmd = oramPkg::cmdRead;
		PAddr = '0;
		DataIn = '0;
		CmdValid = 1'b0;
		DataOutReady = 1'b0;
		for (int a = 0; a < oramPkg::NumBlocks; a++) begin
			shadow[a] = '0;
		end

		repeat (10) @(negedge Clock);
		rst = 1'b0;
		@(negedge Clock);

		fd = $fopen("sim/oramTests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file sim/oramTests.txt");
			abortRun();
		end

		testCount = 0;
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok[7:0] == "#") begin
				// Rest of a comment line
				code = $fgets(lineBuf, fd);
			end else begin
				code = $fscanf(fd, "%s %h %h", opTok, addr, value);
				if (code != 3) begin
					$display("Malformed line in test file after name %0s", tok);
					abortRun();
				end
				testCount++;
				if (opTok == "W") begin
					shadow[addr] = value;
					writeBlock(tok, addr, value);
				end else if (opTok == "R") begin
					// File must agree with its own write history
					if (shadow[addr] !== value) begin
						$display("Test file disagrees with earlier writes in %0s", tok);
						abortRun();
					end
					readBlock(tok, addr, value);
				end else begin
					$display("Unknown operation in test %0s", tok);
					abortRun();
				end
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);

		if (testCount == 0) begin
			$display("Test file held no accesses");
			abortRun();
		end

		repeat (4) @(negedge Clock);
		$display("Regression passed");
		$finish;
	end

endmodule

//--- sim/pathOramTop_chk.sv
/*
 * Handshake and credit assertions for the Path ORAM top level
 */
module pathOramChk (
	input logic Clock,
	input logic rst,
	input logic [oramPkg::CreditWidth-1:0] credits,
	input logic [oramPkg::CreditWidth-1:0] fillCount,
	input logic slotValid,
	input logic [oramPkg::FEDWidth-1:0] DataOut,
	input logic DataOutValid,
	input logic DataOutReady
);

	// Sender never holds more than the buffer depth
	creditBound: assert property (@(posedge Clock) disable iff (rst)
		credits <= oramPkg::CreditWidth'(oramPkg::BufferDepth))
		else $error("treeMemory credit count above buffer depth");

	// Credits keep the FIFO from overrunning
	noOverrun: assert property (@(posedge Clock) disable iff (rst)
		!(slotValid && fillCount == oramPkg::CreditWidth'(oramPkg::BufferDepth)))
		else $error("pathBuffer written while full");

	// Reply held until the network takes it
	replyHeld: assert property (@(posedge Clock) disable iff (rst)
		DataOutValid && !DataOutReady |=> DataOutValid && $stable(DataOut))
		else $error("read reply dropped or changed before DataOutReady");

endmodule

bind pathOramTop pathOramChk chk0 (
	.Clock(Clock),
	.rst(rst),
	.credits(treeMem.credits),
	.fillCount(pathBuf.fillCount),
	.slotValid(slotValid),
	.DataOut(DataOut),
	.DataOutValid(DataOutValid),
	.DataOutReady(DataOutReady)
);

//--- hdl/pathOramTop.sv
/*
 * Path ORAM top level
 * Frontend, tree store, path buffer and stash backend
 */
module pathOramTop (
	input logic Clock,
	input logic rst,
	input oramPkg::oramCmd Cmd,
	input logic [oramPkg::ORAMU-1:0] PAddr,
	input logic [oramPkg::FEDWidth-1:0] DataIn,
	input logic CmdValid,
	output logic CmdReady,
	output logic [oramPkg::FEDWidth-1:0] DataOut,
	output logic DataOutValid,
	input logic DataOutReady
);

	//----------------------------------------------------------------------
	// Interconnect
	//----------------------------------------------------------------------

	// Frontend to backend
	logic accessValid;
	logic accessDone;
	oramPkg::oramCmd accessCmd;
	logic [oramPkg::ORAMU-1:0] accessAddr;
	logic [oramPkg::FEDWidth-1:0] accessData;
	logic [oramPkg::LeafWidth-1:0] oldLeaf;
	logic [oramPkg::LeafWidth-1:0] newLeaf;
	logic [oramPkg::FEDWidth-1:0] replyData;
	logic replyValid;
	logic replyTaken;

	// Path read and write-back
	logic pathStart;
	logic [oramPkg::LeafWidth-1:0] pathLeaf;
	logic wbValid;
	logic [oramPkg::LevelWidth-1:0] wbLevel;
	logic [oramPkg::ORAMZ*oramPkg::slotWidth-1:0] wbSlots;

	// Credit link and buffer output
	logic slotValid;
	logic [oramPkg::slotWidth-1:0] slotData;
	logic creditReturn;
	logic bufValid;
	logic [oramPkg::slotWidth-1:0] bufData;
	logic bufPop;

	//----------------------------------------------------------------------
	// Blocks
	//----------------------------------------------------------------------
	positionMap frontEnd (
		.Clock(Clock), .rst(rst),
		.Cmd(Cmd), .PAddr(PAddr), .DataIn(DataIn),
		.CmdValid(CmdValid), .CmdReady(CmdReady),
		.DataOut(DataOut), .DataOutValid(DataOutValid), .DataOutReady(DataOutReady),
		.AccessValid(accessValid), .AccessCmd(accessCmd), .AccessAddr(accessAddr),
		.AccessData(accessData), .OldLeaf(oldLeaf), .NewLeaf(newLeaf),
		.AccessDone(accessDone), .ReplyData(replyData), .ReplyValid(replyValid),
		.ReplyTaken(replyTaken)
	);

	treeMemory treeMem (
		.Clock(Clock), .rst(rst),
		.PathStart(pathStart), .PathLeaf(pathLeaf),
		.SlotValid(slotValid), .SlotData(slotData), .CreditReturn(creditReturn),
		.WbValid(wbValid), .WbLevel(wbLevel), .WbSlots(wbSlots)
	);

	pathBuffer pathBuf (
		.Clock(Clock), .rst(rst),
		.SlotValid(slotValid), .SlotData(slotData),
		.BufValid(bufValid), .BufData(bufData), .BufPop(bufPop),
		.CreditReturn(creditReturn)
	);

	stashController backEnd (
		.Clock(Clock), .rst(rst),
		.AccessValid(accessValid), .AccessCmd(accessCmd), .AccessAddr(accessAddr),
		.AccessData(accessData), .OldLeaf(oldLeaf), .NewLeaf(newLeaf),
		.AccessDone(accessDone), .PathStart(pathStart), .PathLeaf(pathLeaf),
		.BufValid(bufValid), .BufData(bufData), .BufPop(bufPop),
		.ReplyData(replyData), .ReplyValid(replyValid), .ReplyTaken(replyTaken),
		.WbValid(wbValid), .WbLevel(wbLevel), .WbSlots(wbSlots)
	);

endmodule

//--- hdl/stashController.sv
/*
 * Stash backend
 * Absorbs the path, serves the request, evicts greedily leaf first
 */
module stashController (
	input logic Clock,
	input logic rst,
	input logic AccessValid,
	input oramPkg::oramCmd AccessCmd,
	input logic [oramPkg::ORAMU-1:0] AccessAddr,
	input logic [oramPkg::FEDWidth-1:0] AccessData,
	input logic [oramPkg::LeafWidth-1:0] OldLeaf,
	input logic [oramPkg::LeafWidth-1:0] NewLeaf,
	output logic AccessDone,
	output logic PathStart,
	output logic [oramPkg::LeafWidth-1:0] PathLeaf,
	input logic BufValid,
	input logic [oramPkg::slotWidth-1:0] BufData,
	output logic BufPop,
	output logic [oramPkg::FEDWidth-1:0] ReplyData,
	output logic ReplyValid,
	input logic ReplyTaken,
	output logic WbValid,
	output logic [oramPkg::LevelWidth-1:0] WbLevel,
	output logic [oramPkg::ORAMZ*oramPkg::slotWidth-1:0] WbSlots
);

	oramPkg::stashState state;
	logic [oramPkg::slotWidth-1:0] stash [oramPkg::StashSize];
	logic [oramPkg::PathCntWidth-1:0] absorbCnt;
	logic [oramPkg::LevelWidth-1:0] evictLevel;
	logic [oramPkg::StashIdxWidth-1:0] freeIdx;
	logic [oramPkg::StashIdxWidth-1:0] hitIdx;
	logic hitFound;
	logic [oramPkg::StashSize-1:0] pickMask;
	logic [oramPkg::PickWidth-1:0] pickCnt;
	logic [oramPkg::slotWidth-1:0] servedSlot;

	// Block may sit at this level if the leaf paths agree down to it
	function automatic logic samePrefix(
		input logic [oramPkg::LeafWidth-1:0] a,
		input logic [oramPkg::LeafWidth-1:0] b,
		input logic [oramPkg::LevelWidth-1:0] level
	);
		return (a >> (oramPkg::ORAML - level)) == (b >> (oramPkg::ORAML - level));
	endfunction

	// Path is the block's old leaf
	assign PathLeaf = OldLeaf;
	assign PathStart = (state == oramPkg::stIdle) && AccessValid;
	assign BufPop = (state == oramPkg::stAbsorb) && BufValid;
	assign ReplyValid = state == oramPkg::stReply;
	assign WbValid = state == oramPkg::stEvict;
	assign WbLevel = evictLevel;
	// Root bucket is the last write-back
	assign AccessDone = WbValid && (evictLevel == '0);

	// Requested block after service, always on the new leaf
	assign servedSlot = oramPkg::makeSlot(AccessAddr, NewLeaf,
		(AccessCmd == oramPkg::cmdWrite) ? AccessData : oramPkg::getData(stash[hitIdx]));

	//----------------------------------------------------------------------
	// Stash lookup
	//----------------------------------------------------------------------
	always_comb begin
		freeIdx = '0;
		hitIdx = '0;
		hitFound = 1'b0;
		// Lowest index wins
		for (int i = oramPkg::StashSize - 1; i >= 0; i--) begin
			if (!oramPkg::isValid(stash[i])) begin
				freeIdx = oramPkg::StashIdxWidth'(i);
			end
			if (oramPkg::isValid(stash[i]) && oramPkg::getAddr(stash[i]) == AccessAddr) begin
				hitIdx = oramPkg::StashIdxWidth'(i);
				hitFound = 1'b1;
			end
		end
	end

	// Up to ORAMZ blocks for the bucket at evictLevel
	always_comb begin
		pickMask = '0;
		pickCnt = '0;
		WbSlots = '0;
		for (int i = 0; i < oramPkg::StashSize; i++) begin
			if (oramPkg::isValid(stash[i])
				&& samePrefix(oramPkg::getLeaf(stash[i]), PathLeaf, evictLevel)
				&& pickCnt < oramPkg::PickWidth'(oramPkg::ORAMZ)) begin
				WbSlots[pickCnt*oramPkg::slotWidth +: oramPkg::slotWidth] = stash[i];
				pickMask[i] = 1'b1;
				pickCnt = pickCnt + 1'b1;
			end
		end
	end

	//----------------------------------------------------------------------
	// Access FSM
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= oramPkg::stIdle;
			absorbCnt <= '0;
			evictLevel <= '0;
		end else begin
			case (state)
				oramPkg::stIdle: begin
					if (PathStart) begin
						state <= oramPkg::stAbsorb;
						absorbCnt <= '0;
					end
				end
				oramPkg::stAbsorb: begin
					if (BufPop) begin
						absorbCnt <= absorbCnt + 1'b1;
						if (absorbCnt == oramPkg::PathCntWidth'(oramPkg::PathSlots - 1)) begin
							state <= oramPkg::stServe;
						end
					end
				end
				oramPkg::stServe: begin
					// Eviction starts at the leaf
					evictLevel <= oramPkg::LevelWidth'(oramPkg::ORAML);
					if (AccessCmd == oramPkg::cmdRead) begin
						state <= oramPkg::stReply;
					end else begin
						state <= oramPkg::stEvict;
					end
				end
				oramPkg::stReply: begin
					if (ReplyTaken) begin
						state <= oramPkg::stEvict;
					end
				end
				oramPkg::stEvict: begin
					if (AccessDone) begin
						state <= oramPkg::stIdle;
					end else begin
						evictLevel <= evictLevel - 1'b1;
					end
				end
				default: begin
					state <= oramPkg::stIdle;
				end
			endcase
		end
	end

	// Read result, zero for a block never written
	always_ff @(posedge Clock) begin
		if (state == oramPkg::stServe) begin
			ReplyData <= hitFound ? oramPkg::getData(stash[hitIdx]) : '0;
		end
	end

	//----------------------------------------------------------------------
	// Stash contents
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < oramPkg::StashSize; i++) begin
				stash[i][oramPkg::ValidBit] <= 1'b0;
			end
		end else if (BufPop && oramPkg::isValid(BufData)) begin
			// Empty path slots are dropped
			stash[freeIdx] <= BufData;
		end else if (state == oramPkg::stServe) begin
			if (hitFound) begin
				stash[hitIdx] <= servedSlot;
			end else if (AccessCmd == oramPkg::cmdWrite) begin
				stash[freeIdx] <= servedSlot;
			end
		end else if (WbValid) begin
			for (int i = 0; i < oramPkg::StashSize; i++) begin
				if (pickMask[i]) begin
					stash[i][oramPkg::ValidBit] <= 1'b0;
				end
			end
		end
	end

endmodule

//--- hdl/pathBuffer.sv
/*
 * Read path buffer
 * Slot FIFO that returns one credit per pop
 */
module pathBuffer (
	input logic Clock,
	input logic rst,
	input logic SlotValid,
	input logic [oramPkg::slotWidth-1:0] SlotData,
	output logic BufValid,
	output logic [oramPkg::slotWidth-1:0] BufData,
	input logic BufPop,
	output logic CreditReturn
);

	logic [oramPkg::slotWidth-1:0] fifoMem [oramPkg::BufferDepth];
	logic [oramPkg::PtrWidth-1:0] wrPtr;
	logic [oramPkg::PtrWidth-1:0] rdPtr;
	logic [oramPkg::CreditWidth-1:0] fillCount;

	// Head of queue
	assign BufValid = fillCount != '0;
	assign BufData = fifoMem[rdPtr];

	// Sender never overruns, credits bound the fill
	always_ff @(posedge Clock) begin
		if (SlotValid) begin
			fifoMem[wrPtr] <= SlotData;
		end
	end

	//----------------------------------------------------------------------
	// Pointers, fill level, credit return
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
			CreditReturn <= 1'b0;
		end else begin
			if (SlotValid) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (BufPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			fillCount <= fillCount + oramPkg::CreditWidth'(SlotValid)
				- oramPkg::CreditWidth'(BufPop);
			// Credit goes back a cycle after the pop
			CreditReturn <= BufPop;
		end
	end

endmodule

//--- hdl/treeMemory.sv
/*
 * Bucket tree store
 * Streams one path root first under credits, takes bucket write-back
 */
module treeMemory (
	input logic Clock,
	input logic rst,
	input logic PathStart,
	input logic [oramPkg::LeafWidth-1:0] PathLeaf,
	output logic SlotValid,
	output logic [oramPkg::slotWidth-1:0] SlotData,
	input logic CreditReturn,
	input logic WbValid,
	input logic [oramPkg::LevelWidth-1:0] WbLevel,
	input logic [oramPkg::ORAMZ*oramPkg::slotWidth-1:0] WbSlots
);

	logic [oramPkg::slotWidth-1:0] tree [oramPkg::NumBuckets][oramPkg::ORAMZ];
	logic [oramPkg::LeafWidth-1:0] pathLeafQ;
	logic active;
	logic [oramPkg::LevelWidth-1:0] rdLevel;
	logic [oramPkg::ZWidth-1:0] rdSlot;
	logic [oramPkg::CreditWidth-1:0] credits;
	logic [oramPkg::BucketWidth-1:0] rdBucket;
	logic [oramPkg::BucketWidth-1:0] wbBucket;

	// Heap order, level l starts at index 2^l - 1
	function automatic logic [oramPkg::BucketWidth-1:0] bucketOf(
		input logic [oramPkg::LeafWidth-1:0] leaf,
		input logic [oramPkg::LevelWidth-1:0] level
	);
		return oramPkg::BucketWidth'((1 << level) - 1 + (leaf >> (oramPkg::ORAML - level)));
	endfunction

	assign rdBucket = bucketOf(pathLeafQ, rdLevel);
	assign wbBucket = bucketOf(pathLeafQ, WbLevel);

	// One slot per cycle while credits remain
	assign SlotValid = active && (credits != '0);
	assign SlotData = tree[rdBucket][rdSlot];

	//----------------------------------------------------------------------
	// Path read sequencing
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (PathStart) begin
			pathLeafQ <= PathLeaf;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			active <= 1'b0;
			rdLevel <= '0;
			rdSlot <= '0;
		end else if (PathStart) begin
			active <= 1'b1;
			rdLevel <= '0;
			rdSlot <= '0;
		end else if (SlotValid) begin
			if (rdSlot == oramPkg::ZWidth'(oramPkg::ORAMZ - 1)) begin
				rdSlot <= '0;
				rdLevel <= rdLevel + 1'b1;
				// Leaf bucket done
				if (rdLevel == oramPkg::LevelWidth'(oramPkg::ORAML)) begin
					active <= 1'b0;
				end
			end else begin
				rdSlot <= rdSlot + 1'b1;
			end
		end
	end

	// Credit counter, spent on send, refilled by buffer pops
	always_ff @(posedge Clock) begin
		if (rst) begin
			credits <= oramPkg::CreditWidth'(oramPkg::BufferDepth);
		end else begin
			credits <= credits + oramPkg::CreditWidth'(CreditReturn)
				- oramPkg::CreditWidth'(SlotValid);
		end
	end

	//----------------------------------------------------------------------
	// Bucket storage
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int b = 0; b < oramPkg::NumBuckets; b++) begin
				for (int z = 0; z < oramPkg::ORAMZ; z++) begin
					tree[b][z][oramPkg::ValidBit] <= 1'b0;
				end
			end
		end else if (WbValid) begin
			for (int z = 0; z < oramPkg::ORAMZ; z++) begin
				tree[wbBucket][z] <= WbSlots[z*oramPkg::slotWidth +: oramPkg::slotWidth];
			end
		end else if (SlotValid) begin
			// Slot now lives in the stash
			tree[rdBucket][rdSlot][oramPkg::ValidBit] <= 1'b0;
		end
	end

endmodule

//--- hdl/positionMap.sv
/*
 * Position map frontend
 * Takes network commands, remaps leaves and forwards read replies
 */
module positionMap (
	input logic Clock,
	input logic rst,
	input oramPkg::oramCmd Cmd,
	input logic [oramPkg::ORAMU-1:0] PAddr,
	input logic [oramPkg::FEDWidth-1:0] DataIn,
	input logic CmdValid,
	output logic CmdReady,
	output logic [oramPkg::FEDWidth-1:0] DataOut,
	output logic DataOutValid,
	input logic DataOutReady,
	output logic AccessValid,
	output oramPkg::oramCmd AccessCmd,
	output logic [oramPkg::ORAMU-1:0] AccessAddr,
	output logic [oramPkg::FEDWidth-1:0] AccessData,
	output logic [oramPkg::LeafWidth-1:0] OldLeaf,
	output logic [oramPkg::LeafWidth-1:0] NewLeaf,
	input logic AccessDone,
	input logic [oramPkg::FEDWidth-1:0] ReplyData,
	input logic ReplyValid,
	output logic ReplyTaken
);

	// Current leaf of every block
	logic [oramPkg::LeafWidth-1:0] leafTable [oramPkg::NumBlocks];
	logic [15:0] lfsr;
	logic cmdFire;

	// One access in flight at most
	assign CmdReady = ~AccessValid;
	assign cmdFire = CmdValid & CmdReady;

	// Reply goes straight out, backend holds it
	assign DataOut = ReplyData;
	assign DataOutValid = ReplyValid;
	assign ReplyTaken = ReplyValid & DataOutReady;

	//----------------------------------------------------------------------
	// Leaf source and table
	//----------------------------------------------------------------------

	// Fibonacci LFSR, taps 16 14 13 11
	always_ff @(posedge Clock) begin
		if (rst) begin
			lfsr <= 16'hace1;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	// Initial leaf is address mod leaf count
	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int a = 0; a < oramPkg::NumBlocks; a++) begin
				leafTable[a] <= oramPkg::LeafWidth'(a);
			end
		end else if (cmdFire) begin
			leafTable[PAddr] <= lfsr[oramPkg::LeafWidth-1:0];
		end
	end

	//----------------------------------------------------------------------
	// Access handoff to backend
	//----------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			AccessValid <= 1'b0;
		end else if (AccessDone) begin
			AccessValid <= 1'b0;
		end else if (cmdFire) begin
			AccessValid <= 1'b1;
		end
	end

	// Old leaf read before table update
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			AccessCmd <= Cmd;
			AccessAddr <= PAddr;
			AccessData <= DataIn;
			OldLeaf <= leafTable[PAddr];
			NewLeaf <= lfsr[oramPkg::LeafWidth-1:0];
		end
	end

endmodule

//--- hdl/oramPkg.sv
/*
 * Path ORAM shared geometry, slot layout and enums
 */
package oramPkg;

	//----------------------------------------------------------------------
	// Tree shape
	//----------------------------------------------------------------------
	localparam int ORAML = 3;
	localparam int ORAMZ = 2;
	localparam int PathSlots = (ORAML + 1) * ORAMZ;
	localparam int NumBuckets = (1 << (ORAML + 1)) - 1;

	// Program side
	localparam int ORAMU = 4;
	localparam int NumBlocks = 1 << ORAMU;
	localparam int FEDWidth = 16;
	localparam int LeafWidth = ORAML;

	// Stash holds every block at once
	localparam int StashSize = 16;
	localparam int BufferDepth = 4;

	// Counter and index widths
	localparam int LevelWidth = $clog2(ORAML + 1);
	localparam int ZWidth = $clog2(ORAMZ);
	localparam int BucketWidth = $clog2(NumBuckets);
	localparam int CreditWidth = $clog2(BufferDepth + 1);
	localparam int PtrWidth = $clog2(BufferDepth);
	localparam int PathCntWidth = $clog2(PathSlots);
	localparam int StashIdxWidth = $clog2(StashSize);
	localparam int PickWidth = $clog2(ORAMZ + 1);

	//----------------------------------------------------------------------
	// Slot word, valid on top then address, leaf, data
	//----------------------------------------------------------------------
	localparam int slotWidth = 1 + ORAMU + LeafWidth + FEDWidth;
	localparam int ValidBit = slotWidth - 1;
	localparam int AddrLsb = FEDWidth + LeafWidth;
	localparam int LeafLsb = FEDWidth;

	typedef enum logic {cmdRead, cmdWrite} oramCmd;
	typedef enum logic [2:0] {stIdle, stAbsorb, stServe, stReply, stEvict} stashState;

	// Field access
	function automatic logic isValid(input logic [slotWidth-1:0] s);
		return s[ValidBit];
	endfunction

	function automatic logic [ORAMU-1:0] getAddr(input logic [slotWidth-1:0] s);
		return s[AddrLsb +: ORAMU];
	endfunction

	function automatic logic [LeafWidth-1:0] getLeaf(input logic [slotWidth-1:0] s);
		return s[LeafLsb +: LeafWidth];
	endfunction

	function automatic logic [FEDWidth-1:0] getData(input logic [slotWidth-1:0] s);
		return s[FEDWidth-1:0];
	endfunction

	// New valid block
	function automatic logic [slotWidth-1:0] makeSlot(
		input logic [ORAMU-1:0] addr,
		input logic [LeafWidth-1:0] leaf,
		input logic [FEDWidth-1:0] data
	);
		return {1'b1, addr, leaf, data};
	endfunction

endpackage
